/* logic/subcoord_consts.svh */
`ifndef SUBCOORD_CONSTS_SVH
`define SUBCOORD_CONSTS_SVH

// data word width, integers and floats alike
`define SUBCOORD_WORD_W 32

// coordinate memory address width
`define SUBCOORD_ADDR_W 16

// ieee-754 single precision 1.0
`define SUBCOORD_FLOAT_ONE 32'h3f80_0000

// cycles from add_start to add_done
`define SUBCOORD_ADD_CYCLES 5

`endif

/* logic/subcoord_pkg.sv */
`include "subcoord_consts.svh"

package subcoord_pkg;

    // single precision word
    typedef logic [`SUBCOORD_WORD_W-1:0] float_t;

    typedef enum logic [3:0] {
        idle,
        request,
        start_x,
        start_y,
        point,
        count_fp,
        next_x,
        next_y,
        finish,
        done
    } seq_state_t;

    typedef enum logic {
        fp_add,
        fp_sub
    } fp_op_t;

    // operand pairs presented to the adder
    typedef enum logic [2:0] {
        sel_center_x,
        sel_center_y,
        sel_count,
        sel_step_x,
        sel_step_y
    } operand_sel_t;

endpackage

/* logic/float_adder.sv */
`timescale 1ns/10ps
`include "subcoord_consts.svh"

module float_adder
    import subcoord_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   add_start,
    input  fp_op_t add_op,
    input  float_t add_a,
    input  float_t add_b,
    output logic   add_done,
    output float_t add_result
);

    localparam logic [2:0] last_stage = 3'(`SUBCOORD_ADD_CYCLES - 1);

    logic [2:0]  stage;         // 0 when idle
    float_t      op_a;
    float_t      op_b;          // sign already flipped for subtract
    logic        res_sign;
    logic [7:0]  res_exp;
    logic [23:0] big_m;
    logic [23:0] small_m;
    logic        eff_sub;
    logic [24:0] sum_m;
    logic [32:0] norm;          // {exponent, mantissa} after shifting

    // moves the leading one up by at most 12 places
    function automatic logic [32:0] shift_up(input logic [24:0] m, input logic [7:0] e);
        logic [24:0] mm;
        logic [7:0]  ee;
        mm = m;
        ee = e;
        for (int i = 0; i < 12; i++)
        begin
            if (!mm[24])
            begin
                mm = mm << 1;
                ee = ee - 8'd1;
            end
        end
        return {ee, mm};
    endfunction

    assign norm = shift_up(sum_m, res_exp);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stage    <= '0;
            add_done <= 1'b0;
        end
        else
        begin
            add_done <= 1'b0;
            if (add_start)
                stage <= 3'd1;
            else if (stage == last_stage)
            begin
                stage    <= '0;
                add_done <= 1'b1;
            end
            else if (stage != '0)
                stage <= stage + 3'd1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (add_start)
        begin
            op_a <= add_a;
            op_b <= (add_op == fp_sub) ? {~add_b[31], add_b[30:0]} : add_b;
        end
        if (stage == 3'd1)
        begin
            // larger magnitude sets sign and exponent
            eff_sub <= op_a[31] ^ op_b[31];
            if (op_a[30:0] >= op_b[30:0])
            begin
                res_sign <= op_a[31];
                res_exp  <= op_a[30:23] + 8'd1;
                big_m    <= {1'b1, op_a[22:0]};
                small_m  <= {1'b1, op_b[22:0]} >> (op_a[30:23] - op_b[30:23]);
            end
            else
            begin
                res_sign <= op_b[31];
                res_exp  <= op_b[30:23] + 8'd1;
                big_m    <= {1'b1, op_b[22:0]};
                small_m  <= {1'b1, op_a[22:0]} >> (op_b[30:23] - op_a[30:23]);
            end
        end
        else if (stage == 3'd2)
            sum_m <= eff_sub ? {1'b0, big_m} - {1'b0, small_m} : {1'b0, big_m} + {1'b0, small_m};
        else if (stage == 3'd3)
            {res_exp, sum_m} <= norm;  // first half of normalization
        else if (stage == last_stage)
        begin
            if (op_a[30:0] == '0)
                add_result <= op_b;
            else if (op_b[30:0] == '0)
                add_result <= op_a;
            else if (sum_m == '0)
                add_result <= '0;          // x - x
            else
                add_result <= {res_sign, norm[32:25], norm[23:1]};
        end
    end

endmodule

/* logic/pixel_counter.sv */
`timescale 1ns/10ps
`include "subcoord_consts.svh"

module pixel_counter (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        subset_clear,
    input  logic                        point_step,
    input  logic [`SUBCOORD_WORD_W-1:0] subset_side,
    output logic                        subset_last,
    output logic                        column_end,
    output logic [`SUBCOORD_ADDR_W-1:0] write_addr
);

    logic [`SUBCOORD_WORD_W-1:0] point_count;  // points written in this subset
    logic [`SUBCOORD_WORD_W-1:0] column_pos;   // row index inside current column
    logic [`SUBCOORD_WORD_W-1:0] side_sq;

    assign side_sq     = subset_side * subset_side;
    assign subset_last = (point_count == side_sq);
    // wrapped to zero after a full column
    assign column_end  = (column_pos == '0) && (point_count != '0);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            point_count <= '0;
            column_pos  <= '0;
            write_addr  <= '0;
        end
        else if (subset_clear)
        begin
            point_count <= '0;
            column_pos  <= '0;   // address keeps running
        end
        else if (point_step)
        begin
            point_count <= point_count + 1'b1;
            write_addr  <= write_addr + 1'b1;
            if (column_pos + 1'b1 == subset_side)
                column_pos <= '0;
            else
                column_pos <= column_pos + 1'b1;
        end
    end

endmodule

/* logic/coord_writer.sv */
`timescale 1ns/10ps
`include "subcoord_consts.svh"

module coord_writer
    import subcoord_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  operand_sel_t operand_sel,
    input  float_t       subset_centerpoint_x,
    input  float_t       subset_centerpoint_y,
    input  float_t       half_subset_size,
    input  float_t       pxl_count_fp,
    input  logic         load_x,
    input  logic         load_y,
    input  logic         reload_y,
    input  logic         write_point,
    input  float_t       add_result,
    output float_t       add_a,
    output float_t       add_b,
    output float_t       coord_x,
    output float_t       coord_y,
    output logic         coord_write
);

    float_t first_y;   // top of the column

    always_comb
    begin
        case (operand_sel)
            sel_center_x:
            begin
                add_a = subset_centerpoint_x;
                add_b = half_subset_size;
            end
            sel_center_y:
            begin
                add_a = subset_centerpoint_y;
                add_b = half_subset_size;
            end
            sel_step_x:
            begin
                add_a = coord_x;
                add_b = `SUBCOORD_FLOAT_ONE;
            end
            sel_step_y:
            begin
                add_a = coord_y;
                add_b = `SUBCOORD_FLOAT_ONE;
            end
            default:
            begin
                add_a = pxl_count_fp;
                add_b = `SUBCOORD_FLOAT_ONE;
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (load_x)
            coord_x <= add_result;
        if (load_y)
        begin
            coord_y <= add_result;
            if (operand_sel == sel_center_y)
                first_y <= add_result;  // start point of the subset
        end
        else if (reload_y)
            coord_y <= first_y;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            coord_write <= 1'b0;
        else
            coord_write <= write_point;
    end

endmodule

/* logic/subset_sequencer.sv */
`timescale 1ns/10ps
`include "subcoord_consts.svh"

module subset_sequencer
    import subcoord_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        param_ready,
    input  logic                        coord_interface_done,
    input  logic [`SUBCOORD_WORD_W-1:0] num_of_subsets,
    input  logic                        subset_last,
    input  logic                        column_end,
    input  logic                        add_done,
    input  float_t                      add_result,
    input  logic [`SUBCOORD_ADDR_W-1:0] write_addr,
    output logic                        add_start,
    output fp_op_t                      add_op,
    output operand_sel_t                operand_sel,
    output logic                        load_x,
    output logic                        load_y,
    output logic                        reload_y,
    output logic                        write_point,
    output logic                        subset_clear,
    output logic                        point_step,
    output float_t                      pxl_count_fp,
    output logic                        coord_new_subset,
    output logic                        sub_done,
    output logic [`SUBCOORD_WORD_W-1:0] base_address,
    output logic [`SUBCOORD_WORD_W-1:0] num_pxl_int,
    output logic [`SUBCOORD_WORD_W-1:0] subset_counter,
    output float_t                      num_pxl_fp
);

    seq_state_t                  state;
    logic                        busy;        // adder op in flight
    logic                        uses_adder;
    logic [`SUBCOORD_ADDR_W-1:0] addr_span;   // points written this subset

    assign addr_span = write_addr - base_address[`SUBCOORD_ADDR_W-1:0];

    always_comb
    begin
        uses_adder = (state == start_x) || (state == start_y) || (state == count_fp)
                     || (state == next_x) || (state == next_y);
        add_start  = uses_adder && !busy;
        add_op     = (state == start_x || state == start_y) ? fp_sub : fp_add;
        case (state)
            start_x: operand_sel = sel_center_x;
            start_y: operand_sel = sel_center_y;
            next_x:  operand_sel = sel_step_x;
            next_y:  operand_sel = sel_step_y;
            default: operand_sel = sel_count;
        endcase
        load_x       = add_done && (state == start_x || state == next_x);
        load_y       = add_done && (state == start_y || state == next_y);
        reload_y     = add_done && (state == next_x);  // back to top of column
        write_point  = (state == point);
        subset_clear = (state == request) && coord_interface_done;
        point_step   = (state == count_fp) && !busy;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state            <= idle;
            busy             <= 1'b0;
            pxl_count_fp     <= '0;
            coord_new_subset <= 1'b0;
            sub_done         <= 1'b0;
            base_address     <= '0;
            num_pxl_int      <= '0;
            num_pxl_fp       <= '0;
            subset_counter   <= '0;
        end
        else
        begin
            if (add_start)
                busy <= 1'b1;
            else if (add_done)
                busy <= 1'b0;

            case (state)
                idle:
                begin
                    if (param_ready)
                    begin
                        if (subset_counter < num_of_subsets)
                        begin
                            coord_new_subset <= 1'b1;
                            state            <= request;
                        end
                        else
                        begin
                            sub_done <= 1'b1;
                            state    <= done;
                        end
                    end
                end
                request:
                begin
                    if (coord_interface_done)
                    begin
                        coord_new_subset <= 1'b0;
                        base_address     <= {{(`SUBCOORD_WORD_W-`SUBCOORD_ADDR_W){1'b0}}, write_addr};
                        pxl_count_fp     <= '0;
                        state            <= start_x;
                    end
                end
                start_x:
                    if (add_done)
                        state <= start_y;
                start_y:
                    if (add_done)
                        state <= point;
                point:
                    state <= count_fp;
                count_fp:
                begin
                    if (add_done)
                    begin
                        pxl_count_fp <= add_result;
                        if (subset_last)
                            state <= finish;
                        else if (column_end)
                            state <= next_x;
                        else
                            state <= next_y;
                    end
                end
                next_x, next_y:
                    if (add_done)
                        state <= point;
                finish:
                begin
                    num_pxl_int    <= {{(`SUBCOORD_WORD_W-`SUBCOORD_ADDR_W){1'b0}}, addr_span};
                    num_pxl_fp     <= pxl_count_fp;
                    subset_counter <= subset_counter + 1'b1;
                    if (subset_counter + 1'b1 == num_of_subsets)
                    begin
                        sub_done <= 1'b1;
                        state    <= done;
                    end
                    else
                        state <= idle;
                end
                done:
                    state <= done;   // held until reset
                default:
                    state <= idle;
            endcase
        end
    end

endmodule

/* logic/subcoord_top.sv */
`timescale 1ns/10ps
`include "subcoord_consts.svh"

module subcoord_top
    import subcoord_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        param_ready,
    input  logic                        coord_interface_done,
    input  logic [`SUBCOORD_WORD_W-1:0] num_of_subsets,
    input  float_t                      subset_centerpoint_x,
    input  float_t                      subset_centerpoint_y,
    input  float_t                      half_subset_size,
    input  logic [`SUBCOORD_WORD_W-1:0] subset_size_int,
    output logic                        coord_write,
    output logic [`SUBCOORD_ADDR_W-1:0] coord_addr,
    output float_t                      coord_x,
    output float_t                      coord_y,
    output logic                        coord_new_subset,
    output logic [`SUBCOORD_WORD_W-1:0] base_address,
    output logic [`SUBCOORD_WORD_W-1:0] num_pxl_int,
    output float_t                      num_pxl_fp,
    output logic                        sub_done,
    output logic [`SUBCOORD_WORD_W-1:0] subset_counter
);

    logic         add_start;
    logic         add_done;
    fp_op_t       add_op;
    float_t       add_a;
    float_t       add_b;
    float_t       add_result;
    operand_sel_t operand_sel;
    logic         load_x;
    logic         load_y;
    logic         reload_y;
    logic         write_point;
    logic         subset_clear;
    logic         point_step;
    logic         subset_last;
    logic         column_end;
    float_t       pxl_count_fp;

    subset_sequencer u_sequencer (
        .clock, .reset, .param_ready, .coord_interface_done, .num_of_subsets,
        .subset_last, .column_end, .add_done, .add_result,
        .write_addr (coord_addr),
        .add_start, .add_op, .operand_sel, .load_x, .load_y, .reload_y,
        .write_point, .subset_clear, .point_step, .pxl_count_fp,
        .coord_new_subset, .sub_done, .base_address, .num_pxl_int,
        .subset_counter, .num_pxl_fp
    );

    pixel_counter u_counter (
        .clock, .reset, .subset_clear, .point_step,
        .subset_side (subset_size_int),
        .subset_last, .column_end,
        .write_addr  (coord_addr)
    );

    coord_writer u_writer (
        .clock, .reset, .operand_sel, .subset_centerpoint_x, .subset_centerpoint_y,
        .half_subset_size, .pxl_count_fp, .load_x, .load_y, .reload_y, .write_point,
        .add_result, .add_a, .add_b, .coord_x, .coord_y, .coord_write
    );

    float_adder u_adder (
        .clock, .reset, .add_start, .add_op, .add_a, .add_b, .add_done, .add_result
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clock
);

    initial
        clock = 1'b0;

    // 8 ns period
    always
        #4 clock = ~clock;

endmodule

/* sim/subcoord_checker.sv */
`timescale 1ns/10ps
`include "subcoord_consts.svh"

module subcoord_checker
    import subcoord_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        coord_interface_done,
    input  logic [`SUBCOORD_WORD_W-1:0] num_of_subsets,
    input  int                          expect_first_x,
    input  int                          expect_first_y,
    input  int                          expect_side,
    input  int                          expect_pixels,
    input  logic                        coord_write,
    input  logic [`SUBCOORD_ADDR_W-1:0] coord_addr,
    input  float_t                      coord_x,
    input  float_t                      coord_y,
    input  logic                        coord_new_subset,
    input  logic [`SUBCOORD_WORD_W-1:0] base_address,
    input  logic [`SUBCOORD_WORD_W-1:0] num_pxl_int,
    input  float_t                      num_pxl_fp,
    input  logic                        sub_done,
    input  logic [`SUBCOORD_WORD_W-1:0] subset_counter,
    output int                          tests_passed,
    output int                          tests_failed,
    output bit                          checks_done
);

    localparam int quiet_limit = 40;   // idle cycles watched after sub_done

    logic                        released;
    logic                        in_subset;
    logic                        end_phase;
    logic                        prev_request;  // request pending without interface done
    logic [`SUBCOORD_ADDR_W-1:0] next_addr;
    int errors;
    int sub_idx;
    int points;
    int quiet;
    int lat_first_x;
    int lat_first_y;
    int lat_side;
    int lat_pixels;

    // non-negative integers only
    function automatic logic [31:0] int_to_float(input int value);
        logic [31:0] mag;
        logic [31:0] mant;
        int          msb;
        int          i;
        mag = value;
        msb = -1;
        for (i = 0; i < 32; i++)
        begin
            if (mag[i])
                msb = i;
        end
        if (msb < 0)
            return 32'h0;
        if (msb <= 23)
            mant = mag << (23 - msb);
        else
            mant = mag >> (msb - 23);
        return {1'b0, 8'(127 + msb), mant[22:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("error: %s (subset %0d)", what, sub_idx);
        errors++;
    endtask

    task automatic close_test(input string name);
        if (errors == 0)
        begin
            $display("test %s: pass", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: fail, %0d errors", name, errors);
            tests_failed++;
        end
        errors = 0;
    endtask

    task automatic check_request();
        if (prev_request && !coord_new_subset)
            report_problem("coord_new_subset dropped while coord_interface_done was low");
        if (coord_new_subset && coord_write)
            report_problem("write while a subset request was pending");
        if (coord_new_subset && coord_interface_done)
        begin
            if (in_subset)
                report_problem("new subset started before the previous one ended");
            in_subset   = 1'b1;
            points      = 0;
            lat_first_x = expect_first_x;
            lat_first_y = expect_first_y;
            lat_side    = expect_side;
            lat_pixels  = expect_pixels;
        end
    endtask

    task automatic check_write();
        int col;
        int row;
        if (!in_subset)
            report_problem("write outside of a subset");
        else
        begin
            col = points / lat_side;   // column-major order
            row = points % lat_side;
            check_value("coord_addr", 32'(coord_addr), 32'(next_addr));
            if (points == 0)
                check_value("base_address", base_address, 32'(next_addr));
            check_value("coord_x", coord_x, int_to_float(lat_first_x + col));
            check_value("coord_y", coord_y, int_to_float(lat_first_y + row));
            points++;
            next_addr = next_addr + 1'b1;
        end
    endtask

    task automatic check_subset_end();
        check_value("subset_counter", subset_counter, 32'(sub_idx + 1));
        if (!in_subset)
            report_problem("subset ended without a start");
        if (points != lat_pixels)
            report_problem($sformatf("subset wrote %0d points instead of %0d",
                                     points, lat_pixels));
        check_value("num_pxl_int", num_pxl_int, 32'(lat_pixels));
        check_value("num_pxl_fp", num_pxl_fp, int_to_float(lat_pixels));
        in_subset = 1'b0;
        close_test($sformatf("subset %0d", sub_idx));
        sub_idx++;
    endtask

    task automatic check_quiet();
        if (!end_phase)
        begin
            end_phase = 1'b1;
            check_value("subset_counter", subset_counter, num_of_subsets);
        end
        else
        begin
            quiet++;
            if (!sub_done)
                report_problem("sub_done dropped after the last subset");
            if (coord_new_subset)
                report_problem("new subset requested after the last one");
            if (quiet == quiet_limit)
            begin
                close_test("after last subset");
                checks_done <= 1'b1;
            end
        end
    endtask

    always @(posedge clock)
    begin
        if (reset)
        begin
            released     = 1'b0;
            in_subset    = 1'b0;
            end_phase    = 1'b0;
            prev_request = 1'b0;
            next_addr    = '0;
            errors       = 0;
            sub_idx      = 0;
            points       = 0;
            quiet        = 0;
            tests_passed = 0;
            tests_failed = 0;
            checks_done <= 1'b0;
        end
        else if (!released)
        begin
            released = 1'b1;   // outputs still show reset values here
            check_value("coord_write", 32'(coord_write), 32'h0);
            check_value("coord_new_subset", 32'(coord_new_subset), 32'h0);
            check_value("sub_done", 32'(sub_done), 32'h0);
            check_value("subset_counter", subset_counter, 32'h0);
            check_value("num_pxl_int", num_pxl_int, 32'h0);
            check_value("num_pxl_fp", num_pxl_fp, 32'h0);
            check_value("base_address", base_address, 32'h0);
            close_test("reset values");
        end
        else if (!checks_done)
        begin
            check_request();
            if (coord_write)
                check_write();
            if (subset_counter != 32'(sub_idx))
                check_subset_end();
            if (sub_done || end_phase)
                check_quiet();
            prev_request = coord_new_subset && !coord_interface_done;
        end
    end

endmodule

/* sim/subcoord_tb.sv */
`timescale 1ns/10ps
`include "subcoord_consts.svh"

module subcoord_tb
    import subcoord_pkg::*;
();

    localparam int num_subsets = 4;

    typedef struct packed {
        int cx;
        int cy;
        int side;
        int half;
        int first_x;
        int first_y;
        int pixels;
    } subset_entry_t;

    // center x, center y, side, half side, first x, first y, pixel count
    subset_entry_t subset_table [num_subsets] = '{
        '{10,  20, 3, 1, 9,  19, 9},
        '{5,   7,  1, 0, 5,  7,  1},
        '{100, 50, 4, 2, 98, 48, 16},
        '{33,  64, 2, 1, 32, 63, 4}
    };

    logic                        clock;
    logic                        reset;
    logic                        param_ready;
    logic                        coord_interface_done;
    logic [`SUBCOORD_WORD_W-1:0] num_of_subsets;
    float_t                      subset_centerpoint_x;
    float_t                      subset_centerpoint_y;
    float_t                      half_subset_size;
    logic [`SUBCOORD_WORD_W-1:0] subset_size_int;
    logic                        coord_write;
    logic [`SUBCOORD_ADDR_W-1:0] coord_addr;
    float_t                      coord_x;
    float_t                      coord_y;
    logic                        coord_new_subset;
    logic [`SUBCOORD_WORD_W-1:0] base_address;
    logic [`SUBCOORD_WORD_W-1:0] num_pxl_int;
    float_t                      num_pxl_fp;
    logic                        sub_done;
    logic [`SUBCOORD_WORD_W-1:0] subset_counter;

    int          expect_first_x;
    int          expect_first_y;
    int          expect_side;
    int          expect_pixels;
    int          tests_passed;
    int          tests_failed;
    bit          checks_done;
    int          cycle_count = 0;
    logic [31:0] lfsr_state = 32'h6f6e;

    tb_clock u_clock (.clock);

    subcoord_top u_subcoord_top (
        .clock, .reset, .param_ready, .coord_interface_done, .num_of_subsets,
        .subset_centerpoint_x, .subset_centerpoint_y, .half_subset_size, .subset_size_int,
        .coord_write, .coord_addr, .coord_x, .coord_y, .coord_new_subset, .base_address,
        .num_pxl_int, .num_pxl_fp, .sub_done, .subset_counter
    );

    subcoord_checker u_checker (
        .clock, .reset, .coord_interface_done, .num_of_subsets,
        .expect_first_x, .expect_first_y, .expect_side, .expect_pixels,
        .coord_write, .coord_addr, .coord_x, .coord_y, .coord_new_subset,
        .base_address, .num_pxl_int, .num_pxl_fp, .sub_done, .subset_counter,
        .tests_passed, .tests_failed, .checks_done
    );

    // non-negative integers only
    function automatic logic [31:0] int_to_float(input int value);
        logic [31:0] mag;
        logic [31:0] mant;
        int          msb;
        int          i;
        mag = value;
        msb = -1;
        for (i = 0; i < 32; i++)
        begin
            if (mag[i])
                msb = i;
        end
        if (msb < 0)
            return 32'h0;
        if (msb <= 23)
            mant = mag << (23 - msb);
        else
            mant = mag >> (msb - 23);
        return {1'b0, 8'(127 + msb), mant[22:0]};
    endfunction

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic apply_entry(input int idx);
        subset_entry_t entry;
        entry = subset_table[idx];
        subset_centerpoint_x <= int_to_float(entry.cx);
        subset_centerpoint_y <= int_to_float(entry.cy);
        half_subset_size     <= int_to_float(entry.half);
        subset_size_int      <= entry.side;
        expect_first_x       <= entry.first_x;
        expect_first_y       <= entry.first_y;
        expect_side          <= entry.side;
        expect_pixels        <= entry.pixels;
    endtask

    always @(posedge clock)
        cycle_count <= cycle_count + 1;

    initial
    begin
        int idx;
        int wait_cycles;
        reset                = 1'b1;
        param_ready          = 1'b0;
        coord_interface_done = 1'b0;
        num_of_subsets       = num_subsets;
        subset_centerpoint_x = '0;
        subset_centerpoint_y = '0;
        half_subset_size     = '0;
        subset_size_int      = '0;
        repeat (16) @(posedge clock);
        reset       <= 1'b0;
        param_ready <= 1'b1;
        for (idx = 0; idx < num_subsets; idx++)
        begin
            @(posedge clock);
            while (!coord_new_subset)
                @(posedge clock);
            apply_entry(idx);
            random_bits(4, wait_cycles);   // request held open a while
            repeat (wait_cycles + 1) @(posedge clock);
            coord_interface_done <= 1'b1;
            @(posedge clock);
            coord_interface_done <= 1'b0;
        end
    end

    initial
    begin
        int idx;
        int total_points;
        int cycle_limit;
        bit passed;
        total_points = 0;
        for (idx = 0; idx < num_subsets; idx++)
            total_points += subset_table[idx].pixels;
        cycle_limit = total_points * 40 + 200;
        @(posedge clock);
        while (!checks_done && cycle_count < cycle_limit)
            @(posedge clock);
        if (!checks_done)
            $display("timeout: checks not finished after %0d cycles", cycle_limit);
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        // reset test, one per subset, and the idle tail
        passed = checks_done && (tests_failed == 0) && (tests_passed == num_subsets + 2);
        if (passed)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/subcoord_pkg.sv
logic/float_adder.sv
logic/pixel_counter.sv
logic/coord_writer.sv
logic/subset_sequencer.sv
logic/subcoord_top.sv
sim/tb_clock.sv
sim/subcoord_checker.sv
sim/subcoord_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module subcoord_tb -Mdir obj_dir
./obj_dir/Vsubcoord_tb | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
